// File: flist.f
+incdir+include
verilog/rv_pkg.sv
verilog/register_file.sv
verilog/pipeline_control.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/retire_stage.sv
verilog/rv_pipeline_top.sv
tb/tb_rv_pipeline.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module tb_rv_pipeline \
    -o sim_tb_rv_pipeline

./obj_dir/sim_tb_rv_pipeline | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ======================================================================
// RV32I encoding
// ======================================================================

localparam logic [6:0] F7_BASE = 7'h00;
localparam logic [6:0] F7_ALT  = 7'h20;
localparam logic [2:0] F3_ADD  = 3'b000;
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;
// Immediate bit 10 turns srli into srai
localparam int         SRAI    = 1024;

function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input int rd, input int rs1, input int rs2);
    enc_r = {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [2:0] funct3, input int rd,
                                      input int rs1, input int imm);
    enc_i = {imm[11:0], rs1[4:0], funct3, rd[4:0], 7'b0010011};
endfunction

// ======================================================================
// Sequential reference
// ======================================================================

// Result of one R or I instruction from its source values
function automatic logic [31:0] ref_result(input logic [31:0] insn, input logic [31:0] a,
                                           input logic [31:0] rs2_val);
    logic        r_type;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [63:0] ext_sh;
    r_type = (insn[6:0] == 7'b0110011);
    b      = r_type ? rs2_val : {{20{insn[31]}}, insn[31:20]};
    sh     = b[4:0];
    // Sign-extended copy shifted right gives sra in its low word
    ext_sh = {{32{a[31] & insn[30]}}, a} >> sh;
    case (insn[14:12])
        F3_ADD:  ref_result = (r_type && insn[30]) ? a - b : a + b;
        F3_SLL:  ref_result = a << sh;
        F3_SLT:  ref_result = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        F3_SLTU: ref_result = {31'd0, a < b};
        F3_XOR:  ref_result = a ^ b;
        F3_SR:   ref_result = ext_sh[31:0];
        F3_OR:   ref_result = a | b;
        default: ref_result = a & b;
    endcase
endfunction

// Runs prog_q in order and fills exp_q with every register write
function automatic void run_reference();
    logic [31:0]        model [32];
    logic [31:0]        insn;
    rv_pkg::reg_write_t w;
    model = '{default: '0};
    exp_q.delete();
    foreach (prog_q[i]) begin
        insn   = prog_q[i];
        w.we   = 1'b1;
        w.rd   = insn[11:7];
        if ((insn[6:0] == 7'b0110011 || insn[6:0] == 7'b0010011) && w.rd != 5'd0) begin
            w.data      = ref_result(insn, model[insn[19:15]], model[insn[24:20]]);
            model[w.rd] = w.data;
            exp_q.push_back(w);
        end
    end
endfunction

`endif

// File: tb/tb_rv_pipeline.sv
`timescale 1ns/100ps

module tb_rv_pipeline;

    localparam logic [31:0] RESET_PC      = 32'h0000_0100;
    localparam int          MEM_WORDS     = 1024;
    localparam int          RESET_CYCLES  = 5;
    localparam int          DRAIN_TIMEOUT = 4000;
    localparam int          IDLE_CYCLES   = 8;
    localparam int          RANDOM_COUNT  = 300;

    logic               clk;
    logic               rst_n;
    logic [31:0]        imem_insn;
    logic [31:0]        imem_addr;
    rv_pkg::reg_write_t retire;

    logic [31:0]        prog_mem [MEM_WORDS];
    logic [31:0]        prog_q [$];
    rv_pkg::reg_write_t exp_q [$];
    int                 retire_cycles [$];
    logic [31:0]        addr_trace [$];
    int                 cycle_count;
    int                 seed;
    string              test_name;

    `include "tb_ref_model.svh"

    rv_pipeline_top #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_insn (imem_insn),
        .imem_addr (imem_addr),
        .retire    (retire)
    );

    // Instruction memory answers in the same cycle
    assign imem_insn = prog_mem[imem_addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Rising edges since reset release
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // ======================================================================
    // Checking
    // ======================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        assert (exp == act) else
            abort_run($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                                test_name, what, exp, act));
    endtask

    task automatic check_write(input rv_pkg::reg_write_t exp, input rv_pkg::reg_write_t act);
        assert (act == exp) else
            abort_run($sformatf("[ERROR] %s: expected x%0d=%h, actual x%0d=%h",
                                test_name, exp.rd, exp.data, act.rd, act.data));
    endtask

    // Outputs are sampled on the falling edge, away from the DUT updates
    always @(negedge clk) begin
        if (rst_n) begin
            addr_trace.push_back(imem_addr);
            if (retire.we) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("%s: retire of x%0d when no write was expected",
                                        test_name, retire.rd));
                end else begin
                    check_write(exp_q[0], retire);
                    void'(exp_q.pop_front());
                    retire_cycles.push_back(cycle_count);
                end
            end
        end
    end

    // ======================================================================
    // Program runner
    // ======================================================================

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            // Opcode zero is a bubble, upper bits follow the word address
            prog_mem[10'(i)] = {i[24:0], 7'b0000000};
        end
    endtask

    task automatic run_program(input string name);
        int base;
        int n;
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        test_name = name;
        base      = RESET_PC >> 2;
        fill_memory();
        foreach (prog_q[k]) begin
            prog_mem[10'(base + k)] = prog_q[k];
        end
        run_reference();
        retire_cycles.delete();
        addr_trace.delete();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("pc during reset", RESET_PC, imem_addr);
            assert (!retire.we) else
                abort_run($sformatf("%s: retire active during reset", name));
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("pc at reset release", RESET_PC, imem_addr);
        assert (!retire.we) else
            abort_run($sformatf("%s: retire active at reset release", name));
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%s: timed out with %0d writes still expected",
                                name, exp_q.size()));
        end
        // A few more cycles so that a stray retire is still seen
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge clk);
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    initial begin
        int         r;
        int         rd;
        int         rs1;
        int         rs2;
        int         imm;
        int         held;
        logic [2:0] f3;
        logic [6:0] f7;
        seed  = 14;
        rst_n = 1'b0;
        fill_memory();

        // Sources are set up first and read five or more slots later
        prog_q.delete();
        prog_q.push_back(enc_i(F3_ADD, 1, 0, -5));
        prog_q.push_back(enc_i(F3_ADD, 2, 0, 7));
        prog_q.push_back(enc_i(F3_ADD, 3, 0, 31));
        prog_q.push_back(enc_i(F3_ADD, 4, 0, -2048));
        prog_q.push_back(enc_i(F3_SLTU, 28, 0, -1));
        prog_q.push_back(enc_r(F7_ALT, F3_ADD, 10, 0, 1));
        prog_q.push_back(enc_r(F7_BASE, F3_ADD, 11, 1, 2));
        prog_q.push_back(enc_r(F7_BASE, F3_SLL, 12, 2, 3));
        prog_q.push_back(enc_r(F7_ALT, F3_SR, 13, 4, 3));
        prog_q.push_back(enc_r(F7_BASE, F3_SR, 14, 1, 0));
        prog_q.push_back(enc_r(F7_BASE, F3_AND, 15, 1, 2));
        prog_q.push_back(enc_r(F7_BASE, F3_OR, 16, 1, 4));
        prog_q.push_back(enc_r(F7_BASE, F3_XOR, 17, 2, 4));
        prog_q.push_back(enc_r(F7_BASE, F3_SLT, 18, 1, 2));
        prog_q.push_back(enc_r(F7_BASE, F3_SLTU, 19, 1, 2));
        prog_q.push_back(enc_r(F7_BASE, F3_SR, 20, 1, 3));
        prog_q.push_back(enc_i(F3_SLL, 23, 2, 31));
        prog_q.push_back(enc_i(F3_SR, 24, 1, 31));
        prog_q.push_back(enc_i(F3_SR, 25, 1, SRAI | 31));
        prog_q.push_back(enc_i(F3_SR, 26, 4, SRAI));
        prog_q.push_back(enc_i(F3_SLT, 27, 1, -4));
        prog_q.push_back(enc_i(F3_XOR, 29, 1, -1));
        prog_q.push_back(enc_i(F3_OR, 30, 2, 1792));
        prog_q.push_back(enc_i(F3_AND, 31, 1, 240));
        run_program("alu_directed");
        check_value("first retire cycle", 4, retire_cycles[0]);
        for (int i = 1; i < retire_cycles.size(); i++) begin
            check_value("retire spacing", 1, retire_cycles[i] - retire_cycles[i - 1]);
        end

        prog_q.delete();
        prog_q.push_back(enc_i(F3_ADD, 1, 0, 100));
        prog_q.push_back(enc_r(F7_BASE, F3_ADD, 2, 1, 1));
        prog_q.push_back(enc_r(F7_ALT, F3_ADD, 3, 2, 1));
        run_program("raw_stall");
        // Consumer is fetched once and then held through four stall cycles
        held = 0;
        foreach (addr_trace[i]) begin
            if (addr_trace[i] == RESET_PC + 4) begin
                held++;
            end
        end
        check_value("cycles at consumer address", 5, held);
        check_value("producer to consumer retire", 5, retire_cycles[1] - retire_cycles[0]);

        // Load, store and branch read x1 while it is in flight, then writes to x0
        prog_q.delete();
        prog_q.push_back(enc_i(F3_ADD, 1, 0, 9));
        prog_q.push_back({12'd4, 5'd1, 3'b010, 5'd5, 7'b0000011});
        prog_q.push_back({7'd0, 5'd1, 5'd0, 3'b010, 5'd8, 7'b0100011});
        prog_q.push_back({7'd0, 5'd1, 5'd1, 3'b000, 5'd8, 7'b1100011});
        prog_q.push_back(enc_i(F3_ADD, 0, 0, 5));
        prog_q.push_back(enc_r(F7_BASE, F3_ADD, 0, 1, 1));
        prog_q.push_back(enc_i(F3_ADD, 3, 5, 1));
        prog_q.push_back(enc_r(F7_BASE, F3_ADD, 2, 0, 0));
        run_program("x0_and_bubbles");
        // Nothing here waits on a register, so every address is seen once
        foreach (prog_q[k]) begin
            held = 0;
            foreach (addr_trace[i]) begin
                if (addr_trace[i] == RESET_PC + 4 * k) begin
                    held++;
                end
            end
            check_value("cycles at program address", 1, held);
        end

        prog_q.delete();
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            r   = $random(seed);
            rd  = r & 7;
            rs1 = (r >> 3) & 7;
            rs2 = (r >> 6) & 7;
            f3  = r[11:9];
            if (r[12]) begin
                // Only add and the right shift have an alternate funct7
                f7 = (r[13] && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : F7_BASE;
                prog_q.push_back(enc_r(f7, f3, rd, rs1, rs2));
            end else begin
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    imm = (r >> 20) & 31;
                    if (r[13] && f3 == F3_SR) begin
                        imm = imm | SRAI;
                    end
                end else begin
                    imm = r >>> 20;
                end
                prog_q.push_back(enc_i(f3, rd, rs1, imm));
            end
        end
        run_program("random_alu");

        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_pkg::id_ctrl_t   dec,
    input  logic               stall,
    input  rv_pkg::reg_write_t wr,
    output rv_pkg::id_ex_t     id_ex,
    output rv_pkg::reg_write_t ex_dest
);

    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    rv_pkg::id_ex_t          id_ex_d;
    rv_pkg::id_ex_t          id_ex_q;
    logic                    we_q;

    register_file u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .rs1   (dec.rs1),
        .rs2   (dec.rs2),
        .rd1   (rs1_data),
        .rd2   (rs2_data)
    );

    always_comb begin
        // A stalled instruction enters EX as a bubble
        id_ex_d.we      = dec.we && !stall;
        id_ex_d.rd      = dec.rd;
        id_ex_d.alu_op  = dec.alu_op;
        id_ex_d.imm_sel = dec.imm_sel;
        id_ex_d.op1     = rs1_data;
        id_ex_d.op2     = rs2_data;
        id_ex_d.imm     = dec.imm;
    end

    // ID/EX write enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= id_ex_d.we;
        end
    end

    // ID/EX operands and control
    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
    end

    always_comb begin
        id_ex    = id_ex_q;
        id_ex.we = we_q;
    end

    // Result not known yet, only the destination matters to the interlock
    assign ex_dest = '{we: we_q, rd: id_ex_q.rd, data: '0};

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_pkg::id_ex_t     id_ex,
    output rv_pkg::reg_write_t ex_mem
);

    logic [rv_pkg::XLEN-1:0]       op_a;
    logic [rv_pkg::XLEN-1:0]       op_b;
    logic [4:0]                    shamt;
    logic [rv_pkg::XLEN-1:0]       alu_result;
    logic                          we_q;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_q;
    logic [rv_pkg::XLEN-1:0]       data_q;

    // ======================================================================
    // ALU
    // ======================================================================

    assign op_a  = id_ex.op1;
    assign op_b  = id_ex.imm_sel ? id_ex.imm : id_ex.op2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_pkg::ALU_AND:  alu_result = op_a & op_b;
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            rv_pkg::ALU_SLT:
                alu_result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:
                alu_result = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
            default:          alu_result = '0;
        endcase
    end

    // ======================================================================
    // EX/MEM register
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= id_ex.we;
        end
    end

    always_ff @(posedge clk) begin
        rd_q   <= id_ex.rd;
        data_q <= alu_result;
    end

    assign ex_mem = '{we: we_q, rd: rd_q, data: data_q};

endmodule

// File: verilog/pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] imem_insn,
    input  rv_pkg::reg_write_t      ex_dest,
    input  rv_pkg::reg_write_t      mem_dest,
    input  rv_pkg::reg_write_t      wb_dest,
    input  rv_pkg::reg_write_t      rf_dest,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    output rv_pkg::id_ctrl_t        dec,
    output logic                    stall
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic                    funct7_alt;
    logic                    is_r_type;
    logic                    is_i_type;
    logic                    raw_hit;

    // True when a live destination matches rs1, or rs2 if it is a source
    function automatic logic dest_hit(
        input rv_pkg::reg_write_t          dest,
        input logic [rv_pkg::REG_ADDR_W-1:0] rs1,
        input logic [rv_pkg::REG_ADDR_W-1:0] rs2,
        input logic                        rs2_used
    );
        dest_hit = dest.we && ((dest.rd == rs1) || (rs2_used && (dest.rd == rs2)));
    endfunction

    // ======================================================================
    // Program counter
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (!stall) begin
            pc_q <= pc_q + rv_pkg::XLEN'(4);
        end
    end

    assign imem_addr = pc_q;

    // ======================================================================
    // Instruction decode
    // ======================================================================

    assign opcode     = rv_pkg::opcode_e'(imem_insn[6:0]);
    assign funct3     = imem_insn[14:12];
    assign funct7_alt = imem_insn[30];
    assign is_r_type  = (opcode == rv_pkg::OP_R_TYPE);
    assign is_i_type  = (opcode == rv_pkg::OP_I_TYPE);

    always_comb begin
        dec.rd      = imem_insn[11:7];
        dec.rs1     = imem_insn[19:15];
        dec.rs2     = imem_insn[24:20];
        dec.imm_sel = is_i_type;
        // Sign-extended I-type immediate, shamt sits in its low bits
        dec.imm     = {{(rv_pkg::XLEN-12){imem_insn[31]}}, imem_insn[31:20]};
        // Unknown opcodes and writes to x0 never write back
        dec.we      = (is_r_type || is_i_type) && (imem_insn[11:7] != '0);

        case (funct3)
            // Bit 30 is an immediate bit for addi, so sub is R-type only
            3'b000:  dec.alu_op = (is_r_type && funct7_alt) ? rv_pkg::ALU_SUB
                                                            : rv_pkg::ALU_ADD;
            3'b001:  dec.alu_op = rv_pkg::ALU_SLL;
            3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
            3'b011:  dec.alu_op = rv_pkg::ALU_SLTU;
            3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
            3'b101:  dec.alu_op = funct7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  dec.alu_op = rv_pkg::ALU_OR;
            default: dec.alu_op = rv_pkg::ALU_AND;
        endcase
    end

    // ======================================================================
    // Interlock
    // ======================================================================

    // No forwarding, so wait until the producer has left WB
    assign raw_hit = dest_hit(ex_dest,  dec.rs1, dec.rs2, is_r_type) ||
                     dest_hit(mem_dest, dec.rs1, dec.rs2, is_r_type) ||
                     dest_hit(wb_dest,  dec.rs1, dec.rs2, is_r_type) ||
                     dest_hit(rf_dest,  dec.rs1, dec.rs2, is_r_type);

    // Bubbles read nothing and never stall
    assign stall = (is_r_type || is_i_type) && raw_hit;

endmodule

// File: verilog/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rv_pkg::reg_write_t            wr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::XLEN-1:0]       rd1,
    output logic [rv_pkg::XLEN-1:0]       rd2
);

    localparam int NUM_REGS = 2 ** rv_pkg::REG_ADDR_W;

    logic [rv_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // x0 is hardwired to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verilog/retire_stage.sv
`timescale 1ns/100ps

module retire_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_pkg::reg_write_t ex_mem,
    output rv_pkg::reg_write_t mem_wb,
    output rv_pkg::reg_write_t wb
);

    // Index 0 is MEM/WB, index 1 is WB
    localparam int DEPTH = 2;

    logic [DEPTH-1:0]              we_q;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_q   [DEPTH];
    logic [rv_pkg::XLEN-1:0]       data_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= '0;
        end else begin
            we_q <= {we_q[DEPTH-2:0], ex_mem.we};
        end
    end

    // Memory slot carries the ALU result unchanged
    always_ff @(posedge clk) begin
        rd_q[0]   <= ex_mem.rd;
        data_q[0] <= ex_mem.data;
        rd_q[1]   <= rd_q[0];
        data_q[1] <= data_q[0];
    end

    assign mem_wb = '{we: we_q[0], rd: rd_q[0], data: data_q[0]};
    assign wb     = '{we: we_q[1], rd: rd_q[1], data: data_q[1]};

endmodule

// File: verilog/rv_pipeline_top.sv
`timescale 1ns/100ps

module rv_pipeline_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] imem_insn,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    output rv_pkg::reg_write_t      retire
);

    rv_pkg::id_ctrl_t   dec;
    logic               stall;
    rv_pkg::id_ex_t     id_ex;
    rv_pkg::reg_write_t ex_dest;
    rv_pkg::reg_write_t ex_mem;
    rv_pkg::reg_write_t mem_wb;
    rv_pkg::reg_write_t wb;

    // Fetch, decode and interlock
    pipeline_control #(
        .RESET_PC (RESET_PC)
    ) u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_insn (imem_insn),
        .ex_dest   (ex_dest),
        .mem_dest  (ex_mem),
        .wb_dest   (mem_wb),
        .rf_dest   (wb),
        .imem_addr (imem_addr),
        .dec       (dec),
        .stall     (stall)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .stall   (stall),
        .wr      (wb),
        .id_ex   (id_ex),
        .ex_dest (ex_dest)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    retire_stage u_retire (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .wb     (wb)
    );

    assign retire = wb;

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ======================================================================
    // Encodings
    // ======================================================================

    // Major opcodes handled by the pipeline, anything else is a bubble
    typedef enum logic [6:0] {
        OP_R_TYPE = 7'b0110011,
        OP_I_TYPE = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // ======================================================================
    // Stage payloads
    // ======================================================================

    // Register write, also used as an in-flight destination
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } reg_write_t;

    // Decoded instruction
    // we is already cleared for rd zero and for unknown opcodes
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        alu_op_e               alu_op;
        logic                  imm_sel;
        logic [XLEN-1:0]       imm;
    } id_ctrl_t;

    // ID/EX register contents
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  imm_sel;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

endpackage
